// File: Bender.yml
package:
  name: rx_axi_bridge

sources:
  - files:
      - hw/rx_pkg.sv
      - hw/rx_ingress.sv
      - hw/rx_beat_fifo.sv
      - hw/rx_null_gen.sv
      - hw/rx_egress.sv
      - hw/rx_axi_top.sv
  - target: simulation
    files:
      - verification/rx_axi_tb.sv

// File: hw/rx_axi_top.sv
// RX bridge top level
// TRN receive stream in, AXI4-Stream user stream out

`timescale 1ns/100ps

module rx_axi_top import rx_pkg::*; (
  input  logic     com_iclk,
  input  logic     com_sysrst,
  input  rx_data_t trn_td,
  input  logic     trn_sof,
  input  logic     trn_eof,
  input  logic     trn_rem,
  input  logic     trn_src_dsc,
  input  logic     trn_src_rdy,
  output logic     trn_dst_rdy,
  output rx_data_t m_axis_tdata,
  output rx_keep_t m_axis_tkeep,
  output logic     m_axis_tvalid,
  input  logic     m_axis_tready,
  output logic     m_axis_tlast,
  output rx_eof_t  m_axis_is_eof,
  output logic     m_axis_dsc
);

  // Ingress to FIFO
  logic     wr_valid, wr_ready;
  rx_data_t wr_data;
  rx_keep_t wr_keep;
  logic     wr_sof, wr_eof, wr_dsc;

  // FIFO to egress
  logic     rd_valid, rd_ready;
  rx_data_t rd_data;
  rx_keep_t rd_keep;
  logic     rd_sof, rd_eof, rd_dsc;

  rx_ingress i_ingress (
    .com_iclk, .com_sysrst,
    .trn_td, .trn_sof, .trn_eof, .trn_rem, .trn_src_dsc, .trn_src_rdy, .trn_dst_rdy,
    .wr_valid, .wr_ready, .wr_data, .wr_keep, .wr_sof, .wr_eof, .wr_dsc
  );

  rx_beat_fifo i_fifo (
    .com_iclk, .com_sysrst,
    .wr_valid, .wr_ready, .wr_data, .wr_keep, .wr_sof, .wr_eof, .wr_dsc,
    .rd_valid, .rd_ready, .rd_data, .rd_keep, .rd_sof, .rd_eof, .rd_dsc
  );

  rx_egress i_egress (
    .com_iclk, .com_sysrst,
    .rd_valid, .rd_ready, .rd_data, .rd_keep, .rd_sof, .rd_eof, .rd_dsc,
    .m_axis_tdata, .m_axis_tkeep, .m_axis_tvalid, .m_axis_tready,
    .m_axis_tlast, .m_axis_is_eof, .m_axis_dsc
  );

endmodule

// File: hw/rx_beat_fifo.sv
// RX beat FIFO
// Circular buffer of whole beats with valid/ready on both sides

`timescale 1ns/100ps

module rx_beat_fifo import rx_pkg::*; (
  input  logic     com_iclk,
  input  logic     com_sysrst,
  input  logic     wr_valid,
  output logic     wr_ready,
  input  rx_data_t wr_data,
  input  rx_keep_t wr_keep,
  input  logic     wr_sof,
  input  logic     wr_eof,
  input  logic     wr_dsc,
  output logic     rd_valid,
  input  logic     rd_ready,
  output rx_data_t rd_data,
  output rx_keep_t rd_keep,
  output logic     rd_sof,
  output logic     rd_eof,
  output logic     rd_dsc
);

  // Storage, one slot per beat
  rx_data_t              mem_data [FIFO_DEPTH];
  rx_keep_t              mem_keep [FIFO_DEPTH];
  logic [FIFO_DEPTH-1:0] mem_sof;
  logic [FIFO_DEPTH-1:0] mem_eof;
  logic [FIFO_DEPTH-1:0] mem_dsc;

  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_PTR_W:0]   count;
  logic                  do_wr;
  logic                  do_rd;

  assign wr_ready = (count != (FIFO_PTR_W+1)'(FIFO_DEPTH));
  assign rd_valid = (count != '0);
  assign do_wr    = wr_valid && wr_ready;
  assign do_rd    = rd_valid && rd_ready;

  // Head of queue straight from storage
  assign rd_data = mem_data[rd_ptr];
  assign rd_keep = mem_keep[rd_ptr];
  assign rd_sof  = mem_sof[rd_ptr];
  assign rd_eof  = mem_eof[rd_ptr];
  assign rd_dsc  = mem_dsc[rd_ptr];

  always_ff @(posedge com_iclk) begin
    if (do_wr) begin
      mem_data[wr_ptr] <= wr_data;
      mem_keep[wr_ptr] <= wr_keep;
      mem_sof[wr_ptr]  <= wr_sof;
      mem_eof[wr_ptr]  <= wr_eof;
      mem_dsc[wr_ptr]  <= wr_dsc;
    end
  end

  // Pointers wrap naturally at the power-of-two depth
  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: hw/rx_egress.sv
// RX egress stage
// Drives the user stream from the FIFO and pads a discontinued TLP with null beats

`timescale 1ns/100ps

module rx_egress import rx_pkg::*; (
  input  logic     com_iclk,
  input  logic     com_sysrst,
  input  logic     rd_valid,
  output logic     rd_ready,
  input  rx_data_t rd_data,
  input  rx_keep_t rd_keep,
  input  logic     rd_sof,
  input  logic     rd_eof,
  input  logic     rd_dsc,
  output rx_data_t m_axis_tdata,
  output rx_keep_t m_axis_tkeep,
  output logic     m_axis_tvalid,
  input  logic     m_axis_tready,
  output logic     m_axis_tlast,
  output rx_eof_t  m_axis_is_eof,
  output logic     m_axis_dsc
);

  egress_state_e state;
  egress_state_e state_nxt;
  // Aborted packet still has beats up to a late eof in the FIFO
  logic          drop_after;
  logic          drop_after_nxt;
  logic          null_tlast;
  rx_keep_t      null_keep;
  rx_eof_t       null_is_eof;
  rx_len_t       pkt_len_left;

  // ----------------------------------------
  // Output mux and next state
  // ----------------------------------------
  always_comb begin
    state_nxt      = state;
    drop_after_nxt = drop_after;
    m_axis_tdata   = rd_data;
    m_axis_tkeep   = rd_keep;
    m_axis_tvalid  = 1'b0;
    // Head eof only counts while the FIFO holds a beat
    m_axis_tlast   = rd_valid && rd_eof;
    // Upper half enabled means the last byte is at offset 7
    m_axis_is_eof  = rd_eof ? {1'b1, (rd_keep[4] ? 4'd7 : 4'd3)} : 5'b00011;
    m_axis_dsc     = 1'b0;
    rd_ready       = 1'b0;
    case (state)
      EG_PASS: begin
        // A dsc beat is always swallowed here
        m_axis_tvalid = rd_valid && !rd_dsc;
        rd_ready      = rd_dsc || m_axis_tready;
        if (rd_valid && rd_dsc) begin
          if (!rd_sof && (pkt_len_left > 0)) begin
            state_nxt      = EG_NULL;
            drop_after_nxt = !rd_eof;
          end else if (!rd_eof) begin
            state_nxt = EG_DROP;
          end
        end
      end
      EG_NULL: begin
        m_axis_tdata  = '0;
        m_axis_tkeep  = null_keep;
        m_axis_tvalid = 1'b1;
        m_axis_tlast  = null_tlast;
        m_axis_is_eof = null_is_eof;
        m_axis_dsc    = null_tlast;
        if (m_axis_tready && null_tlast) begin
          state_nxt      = drop_after ? EG_DROP : EG_PASS;
          drop_after_nxt = 1'b0;
        end
      end
      EG_DROP: begin
        rd_ready = 1'b1;
        if (rd_valid && rd_eof) state_nxt = EG_PASS;
      end
      default: state_nxt = EG_PASS;
    endcase
  end

  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      state      <= EG_PASS;
      drop_after <= 1'b0;
    end else begin
      state      <= state_nxt;
      drop_after <= drop_after_nxt;
    end
  end

  // Shadows exactly what the user sees
  rx_null_gen i_null_gen (
    .com_iclk     (com_iclk),
    .com_sysrst   (com_sysrst),
    .s_tdata      (m_axis_tdata),
    .s_tvalid     (m_axis_tvalid),
    .s_tready     (m_axis_tready),
    .s_tlast      (m_axis_tlast),
    .null_tlast   (null_tlast),
    .null_keep    (null_keep),
    .null_is_eof  (null_is_eof),
    .pkt_len_left (pkt_len_left)
  );

endmodule

// File: hw/rx_ingress.sv
// RX ingress stage
// Registers TRN beats, builds byte enables and drops stray beats outside a packet

`timescale 1ns/100ps

module rx_ingress import rx_pkg::*; (
  input  logic     com_iclk,
  input  logic     com_sysrst,
  input  rx_data_t trn_td,
  input  logic     trn_sof,
  input  logic     trn_eof,
  input  logic     trn_rem,
  input  logic     trn_src_dsc,
  input  logic     trn_src_rdy,
  output logic     trn_dst_rdy,
  output logic     wr_valid,
  input  logic     wr_ready,
  output rx_data_t wr_data,
  output rx_keep_t wr_keep,
  output logic     wr_sof,
  output logic     wr_eof,
  output logic     wr_dsc
);

  logic     accept;
  logic     keep_beat;
  logic     in_pkt;
  logic     out_load;
  rx_keep_t beat_keep;

  // Skid register holds one beat while the output is stalled
  logic     skid_valid;
  rx_data_t skid_data;
  rx_keep_t skid_keep;
  logic     skid_sof;
  logic     skid_eof;
  logic     skid_dsc;

  assign accept    = trn_src_rdy && trn_dst_rdy;
  // Beats without sof are only kept inside an open packet
  assign keep_beat = accept && (trn_sof || in_pkt);
  // trn_rem on the eof beat leaves only DW0 in bits 31:0 valid
  assign beat_keep = (trn_eof && trn_rem) ? 8'h0F : 8'hFF;
  // Output register is free when empty or being drained
  assign out_load  = !wr_valid || wr_ready;

  // ----------------------------------------
  // Control
  // ----------------------------------------
  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      wr_valid    <= 1'b0;
      skid_valid  <= 1'b0;
      in_pkt      <= 1'b0;
      trn_dst_rdy <= 1'b0;
    end else begin
      if (keep_beat) begin
        in_pkt <= !trn_eof;
      end
      if (out_load) begin
        // Skid beat goes first, skid is never full while a beat is accepted
        wr_valid   <= skid_valid || keep_beat;
        skid_valid <= 1'b0;
      end else if (keep_beat) begin
        skid_valid <= 1'b1;
      end
      // Ready drops as soon as the skid register fills
      trn_dst_rdy <= out_load || !(skid_valid || keep_beat);
    end
  end

  // ----------------------------------------
  // Payload
  // ----------------------------------------
  always_ff @(posedge com_iclk) begin
    // Capture every cycle while empty, only a kept beat sets skid_valid
    if (!skid_valid) begin
      skid_data <= trn_td;
      skid_keep <= beat_keep;
      skid_sof  <= trn_sof;
      skid_eof  <= trn_eof;
      skid_dsc  <= trn_src_dsc;
    end
    if (out_load) begin
      wr_data <= skid_valid ? skid_data : trn_td;
      wr_keep <= skid_valid ? skid_keep : beat_keep;
      wr_sof  <= skid_valid ? skid_sof  : trn_sof;
      wr_eof  <= skid_valid ? skid_eof  : trn_eof;
      wr_dsc  <= skid_valid ? skid_dsc  : trn_src_dsc;
    end
  end

endmodule

// File: hw/rx_null_gen.sv
// RX null beat generator
// Shadows the user stream and tracks DWORDs left so a cut TLP can be padded

`timescale 1ns/100ps

module rx_null_gen import rx_pkg::*; (
  input  logic     com_iclk,
  input  logic     com_sysrst,
  input  rx_data_t s_tdata,
  input  logic     s_tvalid,
  input  logic     s_tready,
  input  logic     s_tlast,
  output logic     null_tlast,
  output rx_keep_t null_keep,
  output rx_eof_t  null_is_eof,
  output rx_len_t  pkt_len_left
);

  null_state_e state;
  null_state_e state_nxt;
  rx_len_t     len_nxt;
  rx_len_t     len_dec;
  rx_len_t     new_pkt_len;
  rx_len_t     overhead;
  logic        beat_acc;
  logic        pkt_done;
  logic        one_dw_left;

  // Header DW0 fields, DW0 sits in bits 31:0 of the first beat
  logic [1:0]  pkt_fmt;
  logic        pkt_td;
  logic [9:0]  payload_len;

  // ----------------------------------------
  // TLP length from the header
  // ----------------------------------------
  assign pkt_fmt     = s_tdata[30:29];
  assign pkt_td      = s_tdata[15];
  // No payload unless FMT bit 1 is set
  assign payload_len = pkt_fmt[1] ? s_tdata[9:0] : 10'd0;

  // Header plus digest, minus the DWORDs carried by this beat
  always_comb begin
    case ({pkt_fmt[0], pkt_td})
      2'b00:   overhead = rx_len_t'(3 - DW_PER_BEAT);
      2'b01:   overhead = rx_len_t'(4 - DW_PER_BEAT);
      2'b10:   overhead = rx_len_t'(4 - DW_PER_BEAT);
      default: overhead = rx_len_t'(5 - DW_PER_BEAT);
    endcase
  end

  // Zero LENGTH is taken literally, not as 1024 DWORDs
  assign new_pkt_len = overhead + rx_len_t'({2'b00, payload_len});

  assign beat_acc = s_tvalid && s_tready;
  assign len_dec  = pkt_len_left - rx_len_t'(DW_PER_BEAT);
  assign pkt_done = (pkt_len_left <= rx_len_t'(DW_PER_BEAT));

  // ----------------------------------------
  // Mealy FSM
  // ----------------------------------------
  always_comb begin
    state_nxt = state;
    len_nxt   = pkt_len_left;
    case (state)
      NULL_IDLE: begin
        // Single-beat packets are never tracked
        if (beat_acc && !s_tlast) begin
          state_nxt = NULL_IN_PKT;
          len_nxt   = new_pkt_len;
        end
      end
      NULL_IN_PKT: begin
        if (beat_acc && (pkt_done || s_tlast)) begin
          state_nxt = NULL_IDLE;
          len_nxt   = '0;
        end else if (beat_acc) begin
          len_nxt = len_dec;
        end
        // Throttled beat holds the count
      end
      default: begin
        state_nxt = NULL_IDLE;
        len_nxt   = '0;
      end
    endcase
  end

  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      state        <= NULL_IDLE;
      pkt_len_left <= '0;
    end else begin
      state        <= state_nxt;
      pkt_len_left <= len_nxt;
    end
  end

  // ----------------------------------------
  // Null beat shape
  // ----------------------------------------
  assign null_tlast  = pkt_done;
  assign one_dw_left = (pkt_len_left == rx_len_t'(1));

  // Last null beat covers one or two DWORDs
  assign null_keep   = (null_tlast && one_dw_left) ? 8'h0F : 8'hFF;
  assign null_is_eof = !null_tlast ? 5'b00011 :
                       one_dw_left ? 5'b10011 : 5'b10111;

endmodule

// File: hw/rx_pkg.sv
// RX bridge shared definitions
// Datapath sizes, vector types and FSM encodings for the TRN to AXI-Stream path

package rx_pkg;

  // ----------------------------------------
  // Datapath sizes
  // ----------------------------------------

  // Fixed 64-bit datapath, two DWORDs per beat
  localparam int DATA_W      = 64;
  localparam int KEEP_W      = DATA_W / 8;
  localparam int DW_PER_BEAT = DATA_W / 32;

  // Beat FIFO, depth must stay a power of two for pointer wrap
  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

  // Remaining length counter and is_eof field widths
  localparam int LEN_W = 12;
  localparam int EOF_W = 5;

  // ----------------------------------------
  // Vector types
  // ----------------------------------------

  typedef logic [DATA_W-1:0] rx_data_t;
  typedef logic [KEEP_W-1:0] rx_keep_t;

  // DWORDs left in a TLP, may briefly go negative on a bad header
  typedef logic signed [LEN_W-1:0] rx_len_t;

  // Bit 4 marks end of packet, bits 3:0 give last valid byte offset
  typedef logic [EOF_W-1:0] rx_eof_t;

  // ----------------------------------------
  // FSM encodings
  // ----------------------------------------

  // Null generator tracks whether a multi-beat TLP is open
  typedef enum logic {NULL_IDLE, NULL_IN_PKT} null_state_e;

  // Egress forwards, fills with nulls, or flushes an aborted packet
  typedef enum logic [1:0] {EG_PASS, EG_NULL, EG_DROP} egress_state_e;

endpackage

// File: sim.f
hw/rx_pkg.sv
hw/rx_ingress.sv
hw/rx_beat_fifo.sv
hw/rx_null_gen.sv
hw/rx_egress.sv
hw/rx_axi_top.sv
verification/rx_axi_tb.sv

// File: verification/rx_axi_tb.sv
// RX bridge testbench
// Replays golden TRN beats under random back-pressure and checks the user stream

`timescale 1ns/100ps

module rx_axi_tb import rx_pkg::*; ();

  localparam string GOLDEN   = "verification/rx_golden.txt";
  localparam int    BEAT_TMO = 200;
  localparam int    DONE_TMO = 2000;
  localparam int    RDY_TMO  = 20;
  localparam int    DRAIN    = 16;

  logic     com_iclk;
  logic     com_sysrst;
  rx_data_t trn_td;
  logic     trn_sof, trn_eof, trn_rem, trn_src_dsc, trn_src_rdy;
  logic     trn_dst_rdy;
  rx_data_t m_axis_tdata;
  rx_keep_t m_axis_tkeep;
  logic     m_axis_tvalid, m_axis_tready, m_axis_tlast, m_axis_dsc;
  rx_eof_t  m_axis_is_eof;

  // Golden stimulus with input flags packed as {sof, eof, rem, dsc}
  rx_data_t   in_data[$];
  logic [3:0] in_flags[$];
  rx_data_t   ex_data[$];
  rx_keep_t   ex_keep[$];
  logic       ex_last[$];
  rx_eof_t    ex_eof[$];
  logic       ex_dsc[$];
  int         ex_test[$];
  string      names[$];

  int val_errs, tmo_errs, other_errs;
  int got;
  bit running, saw_stall;

  rx_axi_top i_dut (.*);

  always #20 com_iclk = ~com_iclk;

  // ----------------------------------------
  // Golden file and compare helpers
  // ----------------------------------------
  task automatic load_golden();
    int fd;
    int n;
    string line, tag, tname;
    logic [63:0] d;
    logic [7:0] a, b, c, e;
    fd = $fopen(GOLDEN, "r");
    if (fd == 0) begin
      other_errs++;
      $display("Error: cannot open golden file %s", GOLDEN);
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      tag = "";
      n = $fgets(line, fd);
      // Skip comment and blank lines
      if (n > 0 && line.getc(0) != "#") begin
        n = $sscanf(line, "%s", tag);
        if (tag == "T") begin
          n = $sscanf(line, "%s %s", tag, tname);
          names.push_back(tname);
        end else if (tag == "I") begin
          n = $sscanf(line, "%s %h %h %h %h %h", tag, d, a, b, c, e);
          in_data.push_back(d);
          in_flags.push_back({a[0], b[0], c[0], e[0]});
        end else if (tag == "O") begin
          n = $sscanf(line, "%s %h %h %h %h %h", tag, d, a, b, c, e);
          ex_data.push_back(d);
          ex_keep.push_back(a);
          ex_last.push_back(b[0]);
          ex_eof.push_back(c[4:0]);
          ex_dsc.push_back(e[0]);
          ex_test.push_back(names.size() - 1);
        end
      end
    end
    $fclose(fd);
    if (ex_data.size() == 0 || in_data.size() == 0) begin
      other_errs++;
      $display("Error: golden file holds no beats");
    end
  endtask

  task automatic check_field(string tname, string fld, logic [63:0] exp, logic [63:0] act);
    assert (act === exp) else begin
      val_errs++;
      $display("Fail %s %s expected %h actual %h", tname, fld, exp, act);
    end
  endtask

  // Monitor samples at negedge where a beat with valid and ready waits for the next posedge
  always @(negedge com_iclk) begin
    if (running && !trn_dst_rdy) saw_stall = 1'b1;
    if (running && m_axis_tvalid && m_axis_tready) begin
      assert (got < ex_data.size()) else begin
        other_errs++;
        $display("Error: extra user beat with data %h after the last expected beat",
                 m_axis_tdata);
      end
      if (got < ex_data.size()) begin
        check_field(names[ex_test[got]], "tdata", ex_data[got], m_axis_tdata);
        check_field(names[ex_test[got]], "tkeep", ex_keep[got], m_axis_tkeep);
        check_field(names[ex_test[got]], "tlast", ex_last[got], m_axis_tlast);
        check_field(names[ex_test[got]], "is_eof", ex_eof[got], m_axis_is_eof);
        check_field(names[ex_test[got]], "dsc", ex_dsc[got], m_axis_dsc);
        got++;
      end
    end
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  task automatic drive_beats();
    int waited;
    bit acc;
    for (int i = 0; i < in_data.size(); i++) begin
      // Occasional idle gap on the core side
      if ($urandom % 4 == 0) begin
        trn_src_rdy = 1'b0;
        repeat (1 + $urandom % 2) begin
          @(posedge com_iclk);
          #2;
        end
      end
      trn_td = in_data[i];
      {trn_sof, trn_eof, trn_rem, trn_src_dsc} = in_flags[i];
      trn_src_rdy = 1'b1;
      acc = 1'b0;
      waited = 0;
      while (!acc && waited < BEAT_TMO) begin
        @(negedge com_iclk);
        acc = trn_dst_rdy;
        @(posedge com_iclk);
        #2;
        waited++;
      end
      assert (acc) else begin
        tmo_errs++;
        $display("Timeout: trn_dst_rdy stayed low while beat %0d was offered", i);
      end
      if (!acc) begin
        trn_src_rdy = 1'b0;
        return;
      end
    end
    trn_src_rdy = 1'b0;
  endtask

  // Long stall first so the FIFO fills and random low phases after it
  task automatic pace_tready();
    int low;
    m_axis_tready = 1'b0;
    repeat (30) begin
      @(posedge com_iclk);
      #2;
    end
    forever begin
      m_axis_tready = 1'b1;
      @(posedge com_iclk);
      #2;
      if ($urandom % 6 == 0) begin
        low = 2 + $urandom % 10;
        m_axis_tready = 1'b0;
        repeat (low) begin
          @(posedge com_iclk);
          #2;
        end
      end
    end
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    int waited;
    com_iclk      = 1'b0;
    com_sysrst    = 1'b1;
    trn_td        = '0;
    trn_sof       = 1'b0;
    trn_eof       = 1'b0;
    trn_rem       = 1'b0;
    trn_src_dsc   = 1'b0;
    trn_src_rdy   = 1'b0;
    m_axis_tready = 1'b0;
    void'($urandom(32'hb1a5_ccb8));
    load_golden();
    repeat (5) @(posedge com_iclk);
    #2;
    com_sysrst = 1'b0;
    if (other_errs == 0) begin
      // Reset state of both sides
      @(negedge com_iclk);
      check_field("reset", "trn_dst_rdy", 0, trn_dst_rdy);
      check_field("reset", "tvalid", 0, m_axis_tvalid);
      check_field("reset", "tlast", 0, m_axis_tlast);
      check_field("reset", "dsc", 0, m_axis_dsc);
      waited = 0;
      while (!trn_dst_rdy && waited < RDY_TMO) begin
        @(negedge com_iclk);
        waited++;
      end
      assert (trn_dst_rdy) else begin
        tmo_errs++;
        $display("Timeout: trn_dst_rdy never rose after reset");
      end
      check_field("reset", "fifo rd_valid", 0, i_dut.i_fifo.rd_valid);
      @(posedge com_iclk);
      #2;
      running = 1'b1;
      fork
        pace_tready();
      join_none
      drive_beats();
      waited = 0;
      while (got < ex_data.size() && waited < DONE_TMO) begin
        @(posedge com_iclk);
        waited++;
      end
      assert (got >= ex_data.size()) else begin
        tmo_errs++;
        $display("Timeout: only %0d of %0d user beats arrived", got, ex_data.size());
      end
      // Let any extra beat show up
      waited = 0;
      while (waited < DRAIN) begin
        @(posedge com_iclk);
        waited++;
      end
      assert (saw_stall) else begin
        other_errs++;
        $display("Error: trn_dst_rdy never dropped under user back-pressure");
      end
    end
    $display("Errors: %0d value, %0d timeout, %0d other", val_errs, tmo_errs, other_errs);
    if (val_errs + tmo_errs + other_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: verification/rx_golden.txt
# T name | I data sof eof rem dsc | O data keep last is_eof dsc
# All values hex, input beats in TRN order, expected beats in user order
T mwr3_len1
I 010000ff40000001 1 0 0 0
I 00c0ffee10000000 0 1 0 0
O 010000ff40000001 ff 0 03 0
O 00c0ffee10000000 ff 1 17 0
T mwr4_td_len2
I 010000ff60008002 1 0 0 0
I 2000000000000001 0 0 0 0
I a5a5a5a511112222 0 0 0 0
I deadbeef12345678 0 1 1 0
O 010000ff60008002 ff 0 03 0
O 2000000000000001 ff 0 03 0
O a5a5a5a511112222 ff 0 03 0
O deadbeef12345678 0f 1 13 0
T dsc_mid_3dw
I 010000ff40000006 1 0 0 0
I 3333333310000040 0 0 0 0
I 4444444455555555 0 1 0 1
O 010000ff40000006 ff 0 03 0
O 3333333310000040 ff 0 03 0
O 0000000000000000 ff 0 03 0
O 0000000000000000 ff 0 03 0
O 0000000000000000 0f 1 13 1
T dsc_sof_then_mrd
I 010000ff40000004 1 1 0 1
I 010000ff00000001 1 0 0 0
I 0000000010000080 0 1 1 0
O 010000ff00000001 ff 0 03 0
O 0000000010000080 0f 1 13 0
T single_mix_cpld_td
I 1111111122222222 1 1 0 0
I 020000044a008001 1 0 0 0
I 6666666601000000 0 0 0 0
I 0000000077777777 0 1 1 0
I 8888888899999999 1 1 1 0
O 1111111122222222 ff 1 17 0
O 020000044a008001 ff 0 03 0
O 6666666601000000 ff 0 03 0
O 0000000077777777 0f 1 13 0
O 8888888899999999 0f 1 13 0
T dsc_mid_4dw_td
I 010000ff60008005 1 0 0 0
I 0000004000000000 0 0 0 0
I abababab12121212 0 1 0 1
O 010000ff60008005 ff 0 03 0
O 0000004000000000 ff 0 03 0
O 0000000000000000 ff 0 03 0
O 0000000000000000 ff 0 03 0
O 0000000000000000 ff 1 17 1
